//--- rtl/rv_pkg.sv
package rv_pkg;

  localparam int unsigned xlen = 32;

  // Core timer sits in one 64 KiB region
  localparam logic [xlen-1:0] timer_base = 32'h0200_0000;
  localparam logic [xlen-1:0] timer_mask = 32'hffff_0000;

  localparam logic [xlen-1:0] reset_pc = 32'h8000_0000;

  typedef struct packed {
    logic            valid;
    logic [xlen-1:0] addr;
  } rd_req_t;

  typedef struct packed {
    logic            valid;
    logic [xlen-1:0] data;
  } rd_rsp_t;

  typedef struct packed {
    logic            valid;
    logic [xlen-1:0] addr;
    logic [xlen-1:0] data;
  } wr_req_t;

  typedef enum logic [3:0] {
    op_lui,
    op_addi,
    op_add,
    op_sub,
    op_lw,
    op_sw,
    op_beq,
    op_bne,
    op_jal,
    op_nop
  } op_e;

  typedef struct packed {
    op_e             op;
    logic [4:0]      rd;
    logic [xlen-1:0] rs1_val;
    logic [xlen-1:0] rs2_val;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] pc;
  } dec_t;

  typedef enum logic [2:0] {
    st_fetch,
    st_decode,
    st_exec,
    st_mem,
    st_wb
  } core_state_e;

endpackage

//--- rtl/reg_file.sv
module reg_file #(
  parameter int unsigned data_w = rv_pkg::xlen
) (
  input  logic              clk,
  input  logic              arst_n,
  input  logic [4:0]        raddr1,
  input  logic [4:0]        raddr2,
  output logic [data_w-1:0] rdata1,
  output logic [data_w-1:0] rdata2,
  input  logic              wen,
  input  logic [4:0]        waddr,
  input  logic [data_w-1:0] wdata
);

  logic [data_w-1:0] regs [32];

  always_ff @(posedge clk) begin
    if (wen && waddr != 5'd0) begin
      regs[waddr] <= wdata;
    end
  end

  // x0 always reads as zero
  assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

  // Execute must drop writes to x0 before they get here
  a_no_x0_write: assert property (@(posedge clk) disable iff (!arst_n)
    wen |-> (waddr != 5'd0 || wdata == '0));

endmodule

//--- rtl/fetch_unit.sv
module fetch_unit (
  input  logic            clk,
  input  logic            arst_n,
  input  logic            retire,
  input  logic [31:0]     pc_next,
  output rv_pkg::rd_req_t if_rd,
  input  logic            if_rd_ready,
  input  rv_pkg::rd_rsp_t if_rsp,
  output logic            inst_valid,
  output logic [31:0]     inst,
  output logic [31:0]     pc
);
  import rv_pkg::*;

  core_state_e state;
  logic        req_valid;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state      <= st_wb;
      req_valid  <= 1'b0;
      inst_valid <= 1'b0;
      pc         <= reset_pc;
    end else begin
      inst_valid <= 1'b0;
      case (state)
        // First fetch after reset
        st_wb: begin
          req_valid <= 1'b1;
          state     <= st_fetch;
        end
        st_fetch: begin
          if (if_rd_ready) begin
            req_valid <= 1'b0;
            state     <= st_decode;
          end
        end
        st_decode: begin
          if (if_rsp.valid) begin
            inst_valid <= 1'b1;
            state      <= st_exec;
          end
        end
        st_exec: begin
          if (retire) begin
            pc        <= pc_next;
            req_valid <= 1'b1;
            state     <= st_fetch;
          end
        end
        default: state <= st_wb;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == st_decode && if_rsp.valid) begin
      inst <= if_rsp.data;
    end
  end

  assign if_rd.valid = req_valid;
  assign if_rd.addr  = pc;

  a_if_rd_hold: assert property (@(posedge clk) disable iff (!arst_n)
    if_rd.valid && !if_rd_ready |=> if_rd.valid && $stable(if_rd.addr));

endmodule

//--- rtl/decode_unit.sv
module decode_unit (
  input  logic         clk,
  input  logic         arst_n,
  input  logic         inst_valid,
  input  logic [31:0]  inst,
  input  logic [31:0]  pc,
  output logic [4:0]   raddr1,
  output logic [4:0]   raddr2,
  input  logic [31:0]  rdata1,
  input  logic [31:0]  rdata2,
  output rv_pkg::dec_t dec,
  output logic         dec_valid
);
  import rv_pkg::*;

  op_e             op;
  logic [xlen-1:0] imm;
  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];
  assign raddr1 = inst[19:15];
  assign raddr2 = inst[24:20];

  always_comb begin
    op  = op_nop;
    imm = {{20{inst[31]}}, inst[31:20]};
    case (opcode)
      7'b0110111: begin
        op  = op_lui;
        imm = {inst[31:12], 12'b0};
      end
      7'b0010011: if (funct3 == 3'b000) op = op_addi;
      7'b0110011: begin
        if (funct3 == 3'b000 && funct7 == 7'b0000000) op = op_add;
        if (funct3 == 3'b000 && funct7 == 7'b0100000) op = op_sub;
      end
      7'b0000011: if (funct3 == 3'b010) op = op_lw;
      7'b0100011: begin
        if (funct3 == 3'b010) op = op_sw;
        imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
      end
      7'b1100011: begin
        if (funct3 == 3'b000) op = op_beq;
        if (funct3 == 3'b001) op = op_bne;
        imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
      end
      7'b1101111: begin
        op  = op_jal;
        imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
      end
      default: op = op_nop;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= inst_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (inst_valid) begin
      dec.op      <= op;
      dec.rd      <= inst[11:7];
      dec.rs1_val <= rdata1;
      dec.rs2_val <= rdata2;
      dec.imm     <= imm;
      dec.pc      <= pc;
    end
  end

endmodule

//--- rtl/exec_unit.sv
module exec_unit (
  input  logic            clk,
  input  logic            arst_n,
  input  rv_pkg::dec_t    dec,
  input  logic            dec_valid,
  output logic            wen,
  output logic [4:0]      waddr,
  output logic [31:0]     wdata,
  output rv_pkg::rd_req_t ld_req,
  input  logic            ld_ready,
  input  rv_pkg::rd_rsp_t ld_rsp,
  output rv_pkg::wr_req_t st_req,
  input  logic            st_ready,
  output logic [31:0]     pc_next,
  output logic            retire,
  output logic [31:0]     retire_pc
);
  import rv_pkg::*;

  core_state_e     state;
  logic            retire_q;
  logic            ld_valid;
  logic            st_valid;
  logic            taken;
  logic            writes_rd;
  logic [xlen-1:0] alu_res;
  logic [xlen-1:0] pc_seq;
  logic [xlen-1:0] br_target;
  logic [xlen-1:0] mem_addr;
  logic [xlen-1:0] mem_addr_q;
  logic [xlen-1:0] st_data_q;
  logic [xlen-1:0] pc_next_q;
  logic [xlen-1:0] cur_pc;

  assign pc_seq    = dec.pc + 32'd4;
  assign br_target = dec.pc + dec.imm;
  assign mem_addr  = dec.rs1_val + dec.imm;

  always_comb begin
    alu_res   = pc_seq;
    taken     = 1'b0;
    writes_rd = 1'b1;
    case (dec.op)
      op_lui:  alu_res = dec.imm;
      op_addi: alu_res = dec.rs1_val + dec.imm;
      op_add:  alu_res = dec.rs1_val + dec.rs2_val;
      op_sub:  alu_res = dec.rs1_val - dec.rs2_val;
      // Link value is pc+4, already the default
      op_jal:  taken = 1'b1;
      op_beq: begin
        taken     = (dec.rs1_val == dec.rs2_val);
        writes_rd = 1'b0;
      end
      op_bne: begin
        taken     = (dec.rs1_val != dec.rs2_val);
        writes_rd = 1'b0;
      end
      default: writes_rd = 1'b0;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= st_exec;
      retire_q <= 1'b0;
      wen      <= 1'b0;
      ld_valid <= 1'b0;
      st_valid <= 1'b0;
    end else begin
      retire_q <= 1'b0;
      wen      <= 1'b0;
      case (state)
        st_exec: begin
          if (dec_valid) begin
            case (dec.op)
              op_lw: begin
                ld_valid <= 1'b1;
                state    <= st_mem;
              end
              op_sw: begin
                st_valid <= 1'b1;
                state    <= st_mem;
              end
              default: begin
                retire_q <= 1'b1;
                wen      <= writes_rd && dec.rd != 5'd0;
              end
            endcase
          end
        end
        st_mem: begin
          if (ld_valid && ld_ready) ld_valid <= 1'b0;
          // Store retires on the handshake itself
          if (st_valid && st_ready) begin
            st_valid <= 1'b0;
            state    <= st_exec;
          end
          if (ld_rsp.valid) begin
            retire_q <= 1'b1;
            wen      <= waddr != 5'd0;
            state    <= st_exec;
          end
        end
        default: state <= st_exec;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == st_exec && dec_valid) begin
      waddr      <= dec.rd;
      wdata      <= alu_res;
      cur_pc     <= dec.pc;
      pc_next_q  <= taken ? br_target : pc_seq;
      mem_addr_q <= mem_addr;
      st_data_q  <= dec.rs2_val;
    end else if (state == st_mem && ld_rsp.valid) begin
      wdata <= ld_rsp.data;
    end
  end

  assign ld_req.valid = ld_valid;
  assign ld_req.addr  = mem_addr_q;
  assign st_req.valid = st_valid;
  assign st_req.addr  = mem_addr_q;
  assign st_req.data  = st_data_q;

  assign pc_next   = pc_next_q;
  assign retire_pc = cur_pc;
  assign retire    = retire_q | (st_valid & st_ready);

endmodule

//--- rtl/lsu.sv
module lsu (
  input  logic            clk,
  input  logic            arst_n,
  input  rv_pkg::rd_req_t ld_req,
  output logic            ld_ready,
  output rv_pkg::rd_rsp_t ld_rsp,
  input  rv_pkg::wr_req_t st_req,
  output logic            st_ready,
  output rv_pkg::rd_req_t ls_rd,
  input  logic            ls_rd_ready,
  input  rv_pkg::rd_rsp_t ls_rsp,
  output rv_pkg::wr_req_t ext_wr,
  input  logic            ext_wr_ready
);
  import rv_pkg::*;

  logic            rd_valid;
  logic            ld_pend;
  logic [xlen-1:0] rd_addr;

  // One load in flight, from acceptance until its data returns
  assign ld_ready = !ld_pend;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_valid <= 1'b0;
      ld_pend  <= 1'b0;
    end else if (ld_req.valid && ld_ready) begin
      rd_valid <= 1'b1;
      ld_pend  <= 1'b1;
    end else begin
      if (rd_valid && ls_rd_ready) rd_valid <= 1'b0;
      if (ls_rsp.valid) ld_pend <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (ld_req.valid && ld_ready) begin
      rd_addr <= ld_req.addr;
    end
  end

  assign ls_rd.valid  = rd_valid;
  assign ls_rd.addr   = rd_addr;
  assign ld_rsp.valid = ls_rsp.valid && ld_pend;
  assign ld_rsp.data  = ls_rsp.data;

  // Stores go straight out
  assign ext_wr   = st_req;
  assign st_ready = ext_wr_ready;

  a_ld_st_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
    !(ld_pend && st_req.valid));

endmodule

//--- rtl/mem_arbiter.sv
module mem_arbiter (
  input  logic            clk,
  input  logic            arst_n,
  input  rv_pkg::rd_req_t if_rd,
  input  rv_pkg::rd_req_t ls_rd,
  output logic            if_rd_ready,
  output logic            ls_rd_ready,
  output rv_pkg::rd_rsp_t if_rsp,
  output rv_pkg::rd_rsp_t ls_rsp,
  output rv_pkg::rd_req_t arb_rd,
  input  logic            arb_rd_ready,
  input  rv_pkg::rd_rsp_t arb_rsp
);

  logic locked;
  logic owner_ls;
  logic sel_ls;

  // Load/store wins when both ask
  assign sel_ls = ls_rd.valid;

  assign arb_rd.valid = !locked && (ls_rd.valid || if_rd.valid);
  assign arb_rd.addr  = sel_ls ? ls_rd.addr : if_rd.addr;

  assign ls_rd_ready = !locked && sel_ls && arb_rd_ready;
  assign if_rd_ready = !locked && !sel_ls && arb_rd_ready;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      locked   <= 1'b0;
      owner_ls <= 1'b0;
    end else if (arb_rd.valid && arb_rd_ready) begin
      locked   <= 1'b1;
      owner_ls <= sel_ls;
    end else if (arb_rsp.valid) begin
      locked <= 1'b0;
    end
  end

  // Steer the response back to whoever holds the grant
  assign ls_rsp.valid = arb_rsp.valid && owner_ls;
  assign ls_rsp.data  = arb_rsp.data;
  assign if_rsp.valid = arb_rsp.valid && !owner_ls;
  assign if_rsp.data  = arb_rsp.data;

  a_rsp_while_locked: assert property (@(posedge clk) disable iff (!arst_n)
    arb_rsp.valid |-> locked);

endmodule

//--- rtl/addr_xbar.sv
module addr_xbar (
  input  logic            clk,
  input  logic            arst_n,
  input  rv_pkg::rd_req_t arb_rd,
  output logic            arb_rd_ready,
  output rv_pkg::rd_rsp_t arb_rsp,
  output rv_pkg::rd_req_t ext_rd,
  input  logic            ext_rd_ready,
  input  rv_pkg::rd_rsp_t ext_rd_rsp,
  output rv_pkg::rd_req_t tmr_rd,
  input  rv_pkg::rd_rsp_t tmr_rsp
);
  import rv_pkg::*;

  logic hit_tmr;
  logic tgt_tmr;

  assign hit_tmr = (arb_rd.addr & timer_mask) == timer_base;

  assign ext_rd.valid = arb_rd.valid && !hit_tmr;
  assign ext_rd.addr  = arb_rd.addr;
  assign tmr_rd.valid = arb_rd.valid && hit_tmr;
  assign tmr_rd.addr  = arb_rd.addr;

  // Timer never stalls
  assign arb_rd_ready = hit_tmr || ext_rd_ready;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      tgt_tmr <= 1'b0;
    end else if (arb_rd.valid && arb_rd_ready) begin
      tgt_tmr <= hit_tmr;
    end
  end

  assign arb_rsp = tgt_tmr ? tmr_rsp : ext_rd_rsp;

endmodule

//--- rtl/core_timer.sv
module core_timer (
  input  logic            clk,
  input  logic            arst_n,
  input  rv_pkg::rd_req_t tmr_rd,
  output rv_pkg::rd_rsp_t tmr_rsp
);
  import rv_pkg::*;

  logic [63:0]     cnt;
  logic            rsp_valid;
  logic [xlen-1:0] rsp_data;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cnt       <= '0;
      rsp_valid <= 1'b0;
    end else begin
      cnt       <= cnt + 64'd1;
      rsp_valid <= tmr_rd.valid;
    end
  end

  // Offset 4 selects the high word
  always_ff @(posedge clk) begin
    if (tmr_rd.valid) begin
      rsp_data <= tmr_rd.addr[2] ? cnt[63:32] : cnt[31:0];
    end
  end

  assign tmr_rsp.valid = rsp_valid;
  assign tmr_rsp.data  = rsp_data;

endmodule

//--- rtl/rv_core.sv
module rv_core (
  input  logic            clk,
  input  logic            arst_n,
  output rv_pkg::rd_req_t ext_rd,
  input  logic            ext_rd_ready,
  input  rv_pkg::rd_rsp_t ext_rd_rsp,
  output rv_pkg::wr_req_t ext_wr,
  input  logic            ext_wr_ready,
  output logic            retire,
  output logic [31:0]     retire_pc
);
  import rv_pkg::*;

  logic [4:0]      raddr1;
  logic [4:0]      raddr2;
  logic [xlen-1:0] rdata1;
  logic [xlen-1:0] rdata2;
  logic            wen;
  logic [4:0]      waddr;
  logic [xlen-1:0] wdata;

  logic            inst_valid;
  logic [xlen-1:0] inst;
  logic [xlen-1:0] pc;
  logic [xlen-1:0] pc_next;
  dec_t            dec;
  logic            dec_valid;

  rd_req_t         if_rd;
  logic            if_rd_ready;
  rd_rsp_t         if_rsp;
  rd_req_t         ld_req;
  logic            ld_ready;
  rd_rsp_t         ld_rsp;
  wr_req_t         st_req;
  logic            st_ready;
  rd_req_t         ls_rd;
  logic            ls_rd_ready;
  rd_rsp_t         ls_rsp;
  rd_req_t         arb_rd;
  logic            arb_rd_ready;
  rd_rsp_t         arb_rsp;
  rd_req_t         tmr_rd;
  rd_rsp_t         tmr_rsp;

  reg_file u_reg_file (
    .clk(clk), .arst_n(arst_n),
    .raddr1(raddr1), .raddr2(raddr2),
    .rdata1(rdata1), .rdata2(rdata2),
    .wen(wen), .waddr(waddr), .wdata(wdata)
  );

  fetch_unit u_fetch (
    .clk(clk), .arst_n(arst_n),
    .retire(retire), .pc_next(pc_next),
    .if_rd(if_rd), .if_rd_ready(if_rd_ready), .if_rsp(if_rsp),
    .inst_valid(inst_valid), .inst(inst), .pc(pc)
  );

  decode_unit u_decode (
    .clk(clk), .arst_n(arst_n),
    .inst_valid(inst_valid), .inst(inst), .pc(pc),
    .raddr1(raddr1), .raddr2(raddr2),
    .rdata1(rdata1), .rdata2(rdata2),
    .dec(dec), .dec_valid(dec_valid)
  );

  exec_unit u_exec (
    .clk(clk), .arst_n(arst_n),
    .dec(dec), .dec_valid(dec_valid),
    .wen(wen), .waddr(waddr), .wdata(wdata),
    .ld_req(ld_req), .ld_ready(ld_ready), .ld_rsp(ld_rsp),
    .st_req(st_req), .st_ready(st_ready),
    .pc_next(pc_next), .retire(retire), .retire_pc(retire_pc)
  );

  lsu u_lsu (
    .clk(clk), .arst_n(arst_n),
    .ld_req(ld_req), .ld_ready(ld_ready), .ld_rsp(ld_rsp),
    .st_req(st_req), .st_ready(st_ready),
    .ls_rd(ls_rd), .ls_rd_ready(ls_rd_ready), .ls_rsp(ls_rsp),
    .ext_wr(ext_wr), .ext_wr_ready(ext_wr_ready)
  );

  mem_arbiter u_arb (
    .clk(clk), .arst_n(arst_n),
    .if_rd(if_rd), .ls_rd(ls_rd),
    .if_rd_ready(if_rd_ready), .ls_rd_ready(ls_rd_ready),
    .if_rsp(if_rsp), .ls_rsp(ls_rsp),
    .arb_rd(arb_rd), .arb_rd_ready(arb_rd_ready), .arb_rsp(arb_rsp)
  );

  addr_xbar u_xbar (
    .clk(clk), .arst_n(arst_n),
    .arb_rd(arb_rd), .arb_rd_ready(arb_rd_ready), .arb_rsp(arb_rsp),
    .ext_rd(ext_rd), .ext_rd_ready(ext_rd_ready), .ext_rd_rsp(ext_rd_rsp),
    .tmr_rd(tmr_rd), .tmr_rsp(tmr_rsp)
  );

  core_timer u_timer (
    .clk(clk), .arst_n(arst_n),
    .tmr_rd(tmr_rd), .tmr_rsp(tmr_rsp)
  );

endmodule

//--- sim/tb_rv_core.sv
module tb_rv_core;
  import rv_pkg::*;

  localparam logic [31:0] mem_base       = 32'h8000_0000;
  localparam int unsigned mem_words      = 256;
  localparam int unsigned prog_words     = 30;
  localparam logic [31:0] halt_pc        = 32'h8000_0074;
  localparam int unsigned timeout_cycles = 5000;

  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] data;
    logic        tmr;
  } st_rec_t;

  logic        clk;
  logic        arst_n;
  rd_req_t     ext_rd;
  logic        ext_rd_ready;
  rd_rsp_t     ext_rd_rsp;
  wr_req_t     ext_wr;
  logic        ext_wr_ready;
  logic        retire;
  logic [31:0] retire_pc;

  logic [31:0] mem [mem_words];
  logic [31:0] ref_mem [mem_words];
  logic [31:0] ref_regs [32];
  logic        ref_tmr [32];
  logic [31:0] ref_pc;
  st_rec_t     exp_st [$];
  logic [31:0] tmr_vals [$];

  logic        backpressure;
  logic        done;
  logic        rd_pend;
  logic        rd_new;
  int          rd_delay;
  logic [31:0] rd_addr;
  int          n_errors;
  int          n_checks;
  int          n_retired;
  int          n_stores;

  rv_core UUT (
    .clk(clk), .arst_n(arst_n),
    .ext_rd(ext_rd), .ext_rd_ready(ext_rd_ready), .ext_rd_rsp(ext_rd_rsp),
    .ext_wr(ext_wr), .ext_wr_ready(ext_wr_ready),
    .retire(retire), .retire_pc(retire_pc)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] enc_lui(input logic [4:0] rd, input logic [19:0] imm);
    return {imm, rd, 7'b0110111};
  endfunction

  function automatic logic [31:0] enc_addi(input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] enc_alu(input logic [6:0] f7, input logic [4:0] rd,
                                          input logic [4:0] rs1, input logic [4:0] rs2);
    return {f7, rs2, rs1, 3'b000, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_lw(input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [11:0] imm);
    return {imm, rs1, 3'b010, rd, 7'b0000011};
  endfunction

  function automatic logic [31:0] enc_sw(input logic [4:0] rs2, input logic [4:0] rs1,
                                         input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] enc_br(input logic [2:0] f3, input logic [4:0] rs1,
                                         input logic [4:0] rs2, input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] enc_jal(input logic [4:0] rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  function automatic logic in_mem(input logic [31:0] addr);
    return (addr - mem_base) < 32'(mem_words * 4);
  endfunction

  function automatic logic in_tmr(input logic [31:0] addr);
    return (addr & timer_mask) == timer_base;
  endfunction

  function automatic int word_idx(input logic [31:0] addr);
    return int'((addr - mem_base) >> 2);
  endfunction

  // Executes one instruction on the reference state, returns its pc
  function automatic logic [31:0] ref_step();
    logic [31:0] ins;
    logic [31:0] pc;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    logic [31:0] res;
    logic [4:0]  rd;
    logic        wr;
    logic        res_tmr;
    pc      = ref_pc;
    ins     = ref_mem[word_idx(pc)];
    rd      = ins[11:7];
    a       = ref_regs[ins[19:15]];
    b       = ref_regs[ins[24:20]];
    imm_i   = {{20{ins[31]}}, ins[31:20]};
    imm_s   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    imm_b   = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
    imm_j   = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
    ref_pc  = pc + 32'd4;
    res     = '0;
    wr      = 1'b0;
    res_tmr = 1'b0;
    case (ins[6:0])
      7'h37: begin
        res = {ins[31:12], 12'h000};
        wr  = 1'b1;
      end
      7'h13: begin
        res = a + imm_i;
        wr  = (ins[14:12] == 3'd0);
      end
      7'h33: begin
        res = (ins[31:25] == 7'h20) ? a - b : a + b;
        wr  = (ins[14:12] == 3'd0) && (ins[31:25] == 7'h00 || ins[31:25] == 7'h20);
      end
      7'h03: begin
        wr      = (ins[14:12] == 3'd2);
        // Timer values are unknown here, only their order is checked
        res_tmr = in_tmr(a + imm_i);
        res     = in_mem(a + imm_i) ? ref_mem[word_idx(a + imm_i)] : '0;
      end
      7'h23: begin
        if (ins[14:12] == 3'd2) begin
          exp_st.push_back({a + imm_s, b, ref_tmr[ins[24:20]]});
          if (in_mem(a + imm_s)) ref_mem[word_idx(a + imm_s)] = b;
        end
      end
      7'h63: begin
        if ((ins[14:12] == 3'd0 && a == b) || (ins[14:12] == 3'd1 && a != b)) begin
          ref_pc = pc + imm_b;
        end
      end
      7'h6f: begin
        res    = pc + 32'd4;
        wr     = 1'b1;
        ref_pc = pc + imm_j;
      end
      default: wr = 1'b0;
    endcase
    if (wr && rd != 5'd0) begin
      ref_regs[rd] = res;
      ref_tmr[rd]  = res_tmr;
    end
    return pc;
  endfunction

  task automatic load_program();
    logic [31:0] prog [prog_words];
    prog[0]  = enc_lui(5'd1, 20'h80000);
    prog[1]  = enc_lui(5'd2, 20'h12345);
    prog[2]  = enc_addi(5'd2, 5'd2, 12'h678);
    prog[3]  = enc_addi(5'd3, 5'd0, 12'hffb);
    prog[4]  = enc_alu(7'h00, 5'd4, 5'd2, 5'd3);
    prog[5]  = enc_alu(7'h20, 5'd5, 5'd2, 5'd3);
    // Writes to x0 must vanish
    prog[6]  = enc_addi(5'd0, 5'd2, 12'h001);
    prog[7]  = enc_alu(7'h00, 5'd6, 5'd0, 5'd0);
    prog[8]  = enc_sw(5'd4, 5'd1, 12'h200);
    prog[9]  = enc_sw(5'd5, 5'd1, 12'h204);
    prog[10] = enc_sw(5'd6, 5'd1, 12'h208);
    prog[11] = enc_lw(5'd7, 5'd1, 12'h204);
    prog[12] = enc_sw(5'd7, 5'd1, 12'h20c);
    prog[13] = enc_addi(5'd8, 5'd0, 12'h000);
    prog[14] = enc_addi(5'd9, 5'd0, 12'h005);
    // Five-pass loop
    prog[15] = enc_addi(5'd8, 5'd8, 12'h001);
    prog[16] = enc_sw(5'd8, 5'd1, 12'h210);
    prog[17] = enc_br(3'b001, 5'd8, 5'd9, 13'h1ff8);
    prog[18] = enc_br(3'b000, 5'd8, 5'd9, 13'h0008);
    prog[19] = enc_sw(5'd0, 5'd1, 12'h214);
    prog[20] = enc_br(3'b000, 5'd8, 5'd0, 13'h0008);
    prog[21] = enc_jal(5'd10, 21'h00008);
    prog[22] = enc_sw(5'd0, 5'd1, 12'h218);
    prog[23] = enc_sw(5'd10, 5'd1, 12'h218);
    prog[24] = enc_lui(5'd11, 20'h02000);
    prog[25] = enc_lw(5'd12, 5'd11, 12'h000);
    prog[26] = enc_lw(5'd13, 5'd11, 12'h000);
    prog[27] = enc_sw(5'd12, 5'd1, 12'h21c);
    prog[28] = enc_sw(5'd13, 5'd1, 12'h220);
    prog[29] = enc_jal(5'd0, 21'h00000);
    for (int i = 0; i < mem_words; i++) begin
      mem[i] = (mem_base + 32'(i * 4)) ^ 32'h5a5a_a5a5;
      if (i < prog_words) mem[i] = prog[i];
      ref_mem[i] = mem[i];
    end
    for (int r = 0; r < 32; r++) begin
      ref_regs[r] = '0;
      ref_tmr[r]  = 1'b0;
    end
    ref_pc = reset_pc;
    exp_st.delete();
    tmr_vals.delete();
  endtask

  task automatic check_retire();
    logic [31:0] exp_pc;
    exp_pc = ref_step();
    n_checks++;
    if (retire_pc !== exp_pc) begin
      n_errors++;
      $display("error t=%0t retire_pc: got %h, expected %h", $time, retire_pc, exp_pc);
    end
    if (!done) n_retired++;
    if (retire_pc == halt_pc) done = 1'b1;
  endtask

  task automatic check_store();
    st_rec_t e;
    if (exp_st.size() == 0) begin
      n_errors++;
      $display("unexpected store at time %0t to address %h", $time, ext_wr.addr);
    end else begin
      e = exp_st.pop_front();
      n_checks++;
      if (ext_wr.addr !== e.addr) begin
        n_errors++;
        $display("error t=%0t ext_wr.addr: got %h, expected %h", $time, ext_wr.addr, e.addr);
      end
      if (e.tmr) begin
        tmr_vals.push_back(ext_wr.data);
      end else if (ext_wr.data !== e.data) begin
        n_errors++;
        $display("error t=%0t ext_wr.data: got %h, expected %h", $time, ext_wr.data, e.data);
      end
    end
    if (in_mem(ext_wr.addr)) mem[word_idx(ext_wr.addr)] = ext_wr.data;
    if (!done) n_stores++;
  endtask

  // Handshakes are taken at the rising edge
  always @(posedge clk) begin
    if (arst_n) begin
      if (retire) check_retire();
      if (ext_wr.valid && ext_wr_ready) check_store();
      if (ext_rd.valid && ext_rd_ready) begin
        if (in_tmr(ext_rd.addr)) begin
          n_errors++;
          $display("timer read at %h showed up on ext_rd at time %0t", ext_rd.addr, $time);
        end else if (!in_mem(ext_rd.addr)) begin
          n_errors++;
          $display("ext_rd address %h lies outside memory at time %0t", ext_rd.addr, $time);
        end
        rd_pend = 1'b1;
        rd_new  = 1'b1;
        rd_addr = ext_rd.addr;
      end
    end
  end

  // Memory responses and ready signals
  initial begin
    void'($urandom(32'hb690));
    forever begin
      @(negedge clk);
      ext_rd_rsp = '0;
      if (!arst_n) begin
        rd_pend = 1'b0;
        rd_new  = 1'b0;
      end else begin
        if (rd_new) begin
          rd_new   = 1'b0;
          rd_delay = $urandom_range(3, 1);
        end
        if (rd_pend) begin
          rd_delay--;
          if (rd_delay == 0) begin
            ext_rd_rsp.valid = 1'b1;
            ext_rd_rsp.data  = in_mem(rd_addr) ? mem[word_idx(rd_addr)] : '0;
            rd_pend          = 1'b0;
          end
        end
      end
      ext_rd_ready = ($urandom % 3 != 0) || !backpressure;
      ext_wr_ready = ($urandom % 3 != 0) || !backpressure;
    end
  end

  task automatic run_program(input logic bp);
    int cyc;
    arst_n       = 1'b0;
    backpressure = bp;
    done         = 1'b0;
    n_retired    = 0;
    n_stores     = 0;
    load_program();
    repeat (4) @(negedge clk);
    arst_n = 1'b1;
    for (cyc = 0; cyc < timeout_cycles && !done; cyc++) @(negedge clk);
    if (!done) begin
      n_errors++;
      $display("timeout, program never reached its final jump");
      $display("checks %0d, errors %0d", n_checks, n_errors);
      $display("TB FAILED");
      $finish;
    end
    if (exp_st.size() != 0) begin
      n_errors++;
      $display("%0d expected stores never appeared on ext_wr", exp_st.size());
    end
    if (tmr_vals.size() != 2) begin
      n_errors++;
      $display("expected two timer values stored, saw %0d", tmr_vals.size());
    end else if (tmr_vals[1] <= tmr_vals[0]) begin
      n_errors++;
      $display("error t=%0t ext_wr.data: second timer value %h, expected above %h",
               $time, tmr_vals[1], tmr_vals[0]);
    end
  endtask

  initial begin
    int base_retired;
    int base_stores;
    arst_n       = 1'b0;
    ext_rd_ready = 1'b0;
    ext_rd_rsp   = '0;
    ext_wr_ready = 1'b0;
    backpressure = 1'b0;
    done         = 1'b0;
    rd_pend      = 1'b0;
    rd_new       = 1'b0;
    rd_delay     = 0;
    rd_addr      = '0;
    n_errors     = 0;
    n_checks     = 0;
    run_program(1'b0);
    base_retired = n_retired;
    base_stores  = n_stores;
    // Same program again with random stalls on both ports
    run_program(1'b1);
    if (n_retired != base_retired) begin
      n_errors++;
      $display("retired %0d instructions under stalls, %0d without", n_retired, base_retired);
    end
    if (n_stores != base_stores) begin
      n_errors++;
      $display("saw %0d stores under stalls, %0d without", n_stores, base_stores);
    end
    $display("checks %0d, errors %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- filelist.f
rtl/rv_pkg.sv
rtl/reg_file.sv
rtl/fetch_unit.sv
rtl/decode_unit.sv
rtl/exec_unit.sv
rtl/lsu.sv
rtl/mem_arbiter.sv
rtl/addr_xbar.sv
rtl/core_timer.sv
rtl/rv_core.sv
sim/tb_rv_core.sv

//--- Bender.yml
package:
  name: rv_core

sources:
  - rtl/rv_pkg.sv
  - rtl/reg_file.sv
  - rtl/fetch_unit.sv
  - rtl/decode_unit.sv
  - rtl/exec_unit.sv
  - rtl/lsu.sv
  - rtl/mem_arbiter.sv
  - rtl/addr_xbar.sv
  - rtl/core_timer.sv
  - rtl/rv_core.sv
  - target: simulation
    files:
      - sim/tb_rv_core.sv
